// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hart
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+include
hdl/hart_pkg.sv
hdl/fetch_pc.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/load_store.sv
hdl/hart.sv
sim/tb_hart.sv

// File: hdl/alu.sv
/* Integer ALU with add/sub, shifts, logic, set-less-than
   and comparison flags for branches */
`timescale 1ns/1ps

module alu import hart_pkg::*; (
    input  alu_sel_e i_sel,
    input  logic     i_sub,
    input  logic     i_unsigned,
    input  logic     i_arith,
    input  word_t    i_op1,
    input  word_t    i_op2,
    output word_t    o_result,
    output logic     o_eq,
    output logic     o_lt
);

    word_t      sum;
    word_t      sra;   // Arithmetic right shift
    logic [4:0] shamt;

    assign sum   = i_sub ? (i_op1 - i_op2) : (i_op1 + i_op2);
    assign shamt = i_op2[4:0];
    assign sra   = $signed(i_op1) >>> shamt; // Kept apart to stay signed

    // Flags always valid, used by branches and SLT
    assign o_eq = (i_op1 == i_op2);
    assign o_lt = i_unsigned ? (i_op1 < i_op2) : ($signed(i_op1) < $signed(i_op2));

    always_comb begin
        case (i_sel)
            ALU_ADD: o_result = sum;
            ALU_SLL: o_result = i_op1 << shamt;
            ALU_SLT: o_result = {31'b0, o_lt};
            ALU_XOR: o_result = i_op1 ^ i_op2;
            ALU_SR:  o_result = i_arith ? sra : (i_op1 >> shamt);
            ALU_OR:  o_result = i_op1 | i_op2;
            ALU_AND: o_result = i_op1 & i_op2;
            default: o_result = sum;
        endcase
    end

endmodule

// File: hdl/decoder.sv
/* RV32I decoder, field extraction, control and ALU control,
   immediate generation and illegal opcode detection */
`timescale 1ns/1ps

module decoder import hart_pkg::*; (
    input  word_t     i_inst,
    output ctrl_t     o_ctrl,
    output word_t     o_imm,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output reg_addr_t o_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;   // funct7 bit 5, SUB and SRA
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    // Operation class shared by OP and OP-IMM
    function automatic alu_sel_e alu_of(input logic [2:0] f3);
        case (f3)
            3'b001:         return ALU_SLL;
            3'b010, 3'b011: return ALU_SLT;
            3'b100:         return ALU_XOR;
            3'b101:         return ALU_SR;
            3'b110:         return ALU_OR;
            3'b111:         return ALU_AND;
            default:        return ALU_ADD;
        endcase
    endfunction

    // ============================================================
    // Fields and immediates
    // ============================================================
    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign alt    = i_inst[30];
    assign o_rd   = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                    i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                    i_inst[20], i_inst[30:21], 1'b0};

    // ============================================================
    // Control
    // ============================================================
    always_comb begin
        o_ctrl               = '0;
        o_ctrl.alu_sel       = ALU_ADD; // Address and default add
        o_ctrl.wb_sel        = WB_ALU;
        o_ctrl.mem_funct3    = funct3;
        o_ctrl.branch_funct3 = funct3;
        o_imm                = imm_i;

        case (opcode)
            OP_R: begin
                o_ctrl.alu_sel      = alu_of(funct3);
                o_ctrl.sub          = alt & (funct3 == 3'b000);
                o_ctrl.unsigned_cmp = (funct3 == 3'b011);
                o_ctrl.arith        = alt;
                o_ctrl.reg_write    = 1'b1;
            end
            OP_IMM: begin
                o_ctrl.alu_sel      = alu_of(funct3); // ADDI never subtracts
                o_ctrl.unsigned_cmp = (funct3 == 3'b011);
                o_ctrl.arith        = alt & (funct3 == 3'b101); // SRAI only
                o_ctrl.alu_src_imm  = 1'b1;
                o_ctrl.reg_write    = 1'b1;
            end
            OP_LOAD: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_write   = 1'b1;
                o_imm              = imm_s;
            end
            OP_BRANCH: begin
                o_ctrl.unsigned_cmp = funct3[1]; // BLTU, BGEU
                o_ctrl.is_branch    = 1'b1;
                o_imm               = imm_b;
            end
            OP_JAL: begin
                o_ctrl.is_jal    = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_PC4;
                o_imm            = imm_j;
            end
            OP_JALR: begin
                o_ctrl.is_jalr   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_PC4;
            end
            OP_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_IMM;
                o_imm            = imm_u;
            end
            OP_AUIPC: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_sel    = WB_PC_IMM;
                o_imm            = imm_u;
            end
            OP_SYSTEM: begin
                // Other SYSTEM forms fall through as no-ops
                o_ctrl.is_ebreak = (funct3 == 3'b000) && (i_inst[31:20] == 12'h001);
            end
            default: o_ctrl.illegal = 1'b1;
        endcase
    end

endmodule

// File: hdl/fetch_pc.sv
/* Program counter register, branch condition, jump targets
   and next-PC selection with target alignment check */
`timescale 1ns/1ps

module fetch_pc import hart_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  ctrl_t i_ctrl,
    input  word_t i_imm,
    input  word_t i_rs1_data,
    input  logic  i_alu_eq,
    input  logic  i_alu_lt,
    output word_t o_pc,
    output word_t o_pc_plus4,
    output word_t o_next_pc,
    output logic  o_target_misaligned
);

    word_t pc_q;
    word_t rel_target;  // PC + imm, branches and JAL
    word_t jalr_target; // rs1 + imm, bit 0 cleared
    logic  cond, taken, transfer;

    // Branch condition from funct3
    always_comb begin
        case (i_ctrl.branch_funct3)
            3'b000:         cond = i_alu_eq;  // BEQ
            3'b001:         cond = ~i_alu_eq; // BNE
            3'b100, 3'b110: cond = i_alu_lt;  // BLT, BLTU
            3'b101, 3'b111: cond = ~i_alu_lt; // BGE, BGEU
            default:        cond = 1'b0;
        endcase
    end

    assign taken       = i_ctrl.is_branch & cond;
    assign transfer    = taken | i_ctrl.is_jal | i_ctrl.is_jalr;
    assign rel_target  = pc_q + i_imm;
    assign jalr_target = (i_rs1_data + i_imm) & ~32'd1;
    assign o_pc_plus4  = pc_q + 32'd4;

    assign o_next_pc = i_ctrl.is_jalr               ? jalr_target :
                       (i_ctrl.is_jal | taken)       ? rel_target  :
                                                       o_pc_plus4;

    // Only bit 1 can be set on a JALR target
    assign o_target_misaligned = transfer & (o_next_pc[1:0] != 2'b00);
    assign o_pc                = pc_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= RESET_ADDR;
        end else if (!o_target_misaligned) begin // Trapping jump stays put
            pc_q <= o_next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        pc_q[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_q);

endmodule

// File: hdl/hart.sv
/* Single-cycle RV32I hart top level, datapath glue,
   trap and halt logic, write gating and retire record */
`timescale 1ns/1ps

module hart import hart_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic       i_clk,
    input  logic       i_rst,
    output word_t      o_imem_raddr,
    input  word_t      i_imem_rdata,
    output word_t      o_dmem_addr,
    output logic       o_dmem_ren,
    output logic       o_dmem_wen,
    output word_t      o_dmem_wdata,
    output byte_mask_t o_dmem_mask,
    input  word_t      i_dmem_rdata,
    output retire_t    o_retire
);

    ctrl_t     ctrl;
    reg_addr_t rs1, rs2, rd;
    word_t     pc, pc_plus4, next_pc, imm;
    word_t     rs1_data, rs2_data, alu_op2, alu_result;
    word_t     load_data, wb_data;
    logic      alu_eq, alu_lt;
    logic      target_misaligned, mem_misaligned;
    logic      trap, halt, block, rd_wen;

    // ============================================================
    // Fetch and decode
    // ============================================================
    assign o_imem_raddr = pc; // Always word aligned

    fetch_pc #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_ctrl(ctrl), .i_imm(imm), .i_rs1_data(rs1_data),
        .i_alu_eq(alu_eq), .i_alu_lt(alu_lt),
        .o_pc(pc), .o_pc_plus4(pc_plus4), .o_next_pc(next_pc),
        .o_target_misaligned(target_misaligned)
    );

    decoder u_dec (
        .i_inst(i_imem_rdata), .o_ctrl(ctrl), .o_imm(imm),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd)
    );

    reg_file u_rf (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rs1_raddr(rs1), .i_rs2_raddr(rs2),
        .i_rd_waddr(rd), .i_rd_wdata(wb_data), .i_rd_wen(rd_wen),
        .o_rs1_rdata(rs1_data), .o_rs2_rdata(rs2_data)
    );

    // ============================================================
    // Execute and memory
    // ============================================================
    assign alu_op2 = ctrl.alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .i_sel(ctrl.alu_sel), .i_sub(ctrl.sub), .i_unsigned(ctrl.unsigned_cmp),
        .i_arith(ctrl.arith), .i_op1(rs1_data), .i_op2(alu_op2),
        .o_result(alu_result), .o_eq(alu_eq), .o_lt(alu_lt)
    );

    load_store u_lsu (
        .i_ctrl(ctrl), .i_addr(alu_result), .i_store_data(rs2_data),
        .i_dmem_rdata(i_dmem_rdata), .i_block(block),
        .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen),
        .o_dmem_wdata(o_dmem_wdata), .o_dmem_mask(o_dmem_mask),
        .o_load_data(load_data), .o_misaligned(mem_misaligned)
    );

    // Write-back source
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:    wb_data = load_data;
            WB_PC4:    wb_data = pc_plus4;
            WB_IMM:    wb_data = imm;
            WB_PC_IMM: wb_data = pc + imm; // AUIPC
            default:   wb_data = alu_result;
        endcase
    end

    // ============================================================
    // Trap, halt and retire
    // ============================================================
    assign trap   = ctrl.illegal | target_misaligned | mem_misaligned;
    assign halt   = trap | ctrl.is_ebreak;
    assign block  = trap | i_rst; // No architectural writes
    assign rd_wen = ctrl.reg_write & ~block;

    always_comb begin
        o_retire.valid    = ~i_rst;
        o_retire.trap     = trap;
        o_retire.halt     = halt;
        o_retire.inst     = i_imem_rdata;
        o_retire.pc       = pc;
        o_retire.next_pc  = next_pc;
        // Zero when nothing is written or rd is x0
        o_retire.rd_waddr = rd_wen ? rd : '0;
        o_retire.rd_wdata = (rd_wen && rd != '0) ? wb_data : '0;
    end

    // Lane count of a store matches its access size
    a_wen_mask: assert property (@(posedge i_clk) disable iff (i_rst)
        o_dmem_wen |-> ($countones(o_dmem_mask) ==
                        (ctrl.mem_funct3[1] ? 4 : (ctrl.mem_funct3[0] ? 2 : 1))))
        else $error("store byte mask does not match access size");

endmodule

// File: hdl/hart_pkg.sv
/* Shared widths, RV32I opcode constants, ALU and write-back enums,
   decoder control struct and retire record */
package hart_pkg;

    typedef logic [31:0] word_t;      // Data, address and instruction word
    typedef logic [4:0]  reg_addr_t;  // Register index
    typedef logic [3:0]  byte_mask_t; // One bit per byte lane

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ALU operation class, encoded like funct3
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SLL = 3'b001,
        ALU_SLT = 3'b010, // SLT and SLTU, split by unsigned_cmp
        ALU_XOR = 3'b100,
        ALU_SR  = 3'b101, // SRL and SRA, split by arith
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_sel_e;

    // Register write-back source
    typedef enum logic [2:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,   // Link address
        WB_IMM,   // LUI
        WB_PC_IMM // AUIPC
    } wb_sel_e;

    typedef struct packed {
        alu_sel_e   alu_sel;
        logic       sub;
        logic       unsigned_cmp;
        logic       arith;
        logic       alu_src_imm;   // Operand 2 is the immediate
        logic       mem_read;
        logic       mem_write;
        logic [2:0] mem_funct3;    // Access size and signedness
        logic       reg_write;
        wb_sel_e    wb_sel;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] branch_funct3;
        logic       is_ebreak;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      trap;
        logic      halt;
        word_t     inst;
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd_waddr;
        word_t     rd_wdata;
    } retire_t;

endpackage

// File: hdl/load_store.sv
/* Load/store unit, word-aligned address, store lanes and mask,
   load extraction with extension and misalignment check */
`timescale 1ns/1ps

module load_store import hart_pkg::*; (
    input  ctrl_t      i_ctrl,
    input  word_t      i_addr,
    input  word_t      i_store_data,
    input  word_t      i_dmem_rdata,
    input  logic       i_block,      // Trap or reset
    output word_t      o_dmem_addr,
    output logic       o_dmem_ren,
    output logic       o_dmem_wen,
    output word_t      o_dmem_wdata,
    output byte_mask_t o_dmem_mask,
    output word_t      o_load_data,
    output logic       o_misaligned
);

    logic [1:0] off;       // Byte offset in word
    logic [1:0] size;      // 0 byte, 1 half, 2 word
    logic       bad_align;
    word_t      lane_data; // Addressed lane moved to bit 0

    assign off  = i_addr[1:0];
    assign size = i_ctrl.mem_funct3[1:0];

    assign o_dmem_addr = {i_addr[31:2], 2'b00};
    assign o_dmem_ren  = i_ctrl.mem_read & ~i_block;
    assign o_dmem_wen  = i_ctrl.mem_write & ~i_block;

    // Store lanes
    assign o_dmem_wdata = i_store_data << {off, 3'b000};

    always_comb begin
        case (size)
            2'b00:   o_dmem_mask = 4'b0001 << off;
            2'b01:   o_dmem_mask = 4'b0011 << off;
            default: o_dmem_mask = 4'b1111;
        endcase
    end

    // Alignment by access size
    always_comb begin
        case (size)
            2'b00:   bad_align = 1'b0;
            2'b01:   bad_align = off[0];
            default: bad_align = |off;
        endcase
    end

    assign o_misaligned = (i_ctrl.mem_read | i_ctrl.mem_write) & bad_align;

    // Load extraction
    assign lane_data = i_dmem_rdata >> {off, 3'b000};

    always_comb begin
        case (i_ctrl.mem_funct3)
            3'b000:  o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};   // LB
            3'b001:  o_load_data = {{16{lane_data[15]}}, lane_data[15:0]}; // LH
            3'b100:  o_load_data = {24'b0, lane_data[7:0]};                // LBU
            3'b101:  o_load_data = {16'b0, lane_data[15:0]};               // LHU
            default: o_load_data = lane_data;                              // LW
        endcase
    end

endmodule

// File: hdl/reg_file.sv
/* Integer register file, x0 held at zero,
   two combinational read ports and one write port */
`timescale 1ns/1ps

module reg_file import hart_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_rs1_raddr,
    input  reg_addr_t i_rs2_raddr,
    input  reg_addr_t i_rd_waddr,
    input  word_t     i_rd_wdata,
    input  logic      i_rd_wen,
    output word_t     o_rs1_rdata,
    output word_t     o_rs2_rdata
);

    word_t regs [32]; // x0 cleared by reset, never written

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && i_rd_waddr != '0) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    // Reads see the old value during a write cycle
    assign o_rs1_rdata = regs[i_rs1_raddr];
    assign o_rs2_rdata = regs[i_rs2_raddr];

    // x0 stays zero even after a write aimed at it
    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_rs1_raddr != '0) || (o_rs1_rdata == '0)) &&
        ((i_rs2_raddr != '0) || (o_rs2_rdata == '0)))
        else $error("x0 read returned non-zero");

endmodule

// File: include/rv_ref_model.svh
/* Reference model of one RV32I instruction acting on
   shadow registers and shadow data memory */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

word_t shadow_regs [32];  // Architectural registers, x0 kept zero
word_t shadow_mem  [256]; // Mirror of the 1 KiB data memory

// Integer result for OP and OP-IMM by funct3
function automatic word_t alu_ref(input logic [2:0] f3, input word_t a, input word_t b,
                                  input logic alt, input logic is_r);
    case (f3)
        3'd0:    return (is_r && alt) ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// Half needs even address, word needs a multiple of four
function automatic logic misaligned(input logic [2:0] f3, input logic [1:0] off);
    case (f3[1:0])
        2'd0:    return 1'b0;
        2'd1:    return off[0];
        default: return |off;
    endcase
endfunction

function automatic retire_t ref_step(input word_t pc, input word_t inst);
    retire_t    r;
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a, b, imm_i, imm_s, imm_b, imm_j, addr, word, val;
    logic       wen, taken, xfer, mis;
    logic [1:0] off;
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = shadow_regs[inst[19:15]];
    b     = shadow_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    r       = '0;
    r.valid = 1'b1;
    r.inst  = inst;
    r.pc    = pc;
    r.next_pc = pc + 32'd4;
    wen   = 1'b0;
    val   = '0;
    taken = 1'b0;
    xfer  = 1'b0;
    mis   = 1'b0;
    addr = a + ((inst[6:0] == OP_STORE) ? imm_s : imm_i);
    off  = addr[1:0];
    word = shadow_mem[addr[9:2]];
    case (inst[6:0])
        OP_R, OP_IMM: begin
            val = alu_ref(f3, a, (inst[6:0] == OP_R) ? b : imm_i, inst[30],
                          inst[6:0] == OP_R);
            wen = 1'b1;
        end
        OP_LUI: begin
            val = {inst[31:12], 12'b0};
            wen = 1'b1;
        end
        OP_AUIPC: begin
            val = pc + {inst[31:12], 12'b0};
            wen = 1'b1;
        end
        OP_JAL: begin
            xfer      = 1'b1;
            r.next_pc = pc + imm_j;
            val       = pc + 32'd4;
            wen       = 1'b1;
        end
        OP_JALR: begin
            xfer      = 1'b1;
            r.next_pc = (a + imm_i) & ~32'd1;
            val       = pc + 32'd4;
            wen       = 1'b1;
        end
        OP_BRANCH: begin
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = $signed(a) < $signed(b);
                3'd5: taken = $signed(a) >= $signed(b);
                3'd6: taken = a < b;
                3'd7: taken = a >= b;
                default: taken = 1'b0; // Reserved forms never branch
            endcase
            xfer = taken;
            if (taken) r.next_pc = pc + imm_b;
        end
        OP_LOAD: begin
            mis = misaligned(f3, off);
            wen = 1'b1;
            case (f3)
                3'd0:    val = {{24{word[8*off+7]}}, word[8*off +: 8]};
                3'd1:    val = {{16{word[8*off+15]}}, word[8*off +: 16]};
                3'd4:    val = {24'b0, word[8*off +: 8]};
                3'd5:    val = {16'b0, word[8*off +: 16]};
                default: val = word;
            endcase
        end
        OP_STORE: begin
            mis = misaligned(f3, off);
            if (!mis) begin
                case (f3[1:0])
                    2'd0:    word[8*off +: 8]  = b[7:0];
                    2'd1:    word[8*off +: 16] = b[15:0];
                    default: word = b;
                endcase
                shadow_mem[addr[9:2]] = word;
            end
        end
        OP_SYSTEM: r.halt = (f3 == 3'd0) && (inst[31:20] == 12'h001); // EBREAK
        default:   r.trap = 1'b1; // Unknown opcode
    endcase
    if ((xfer && r.next_pc[1:0] != 2'b00) || mis) r.trap = 1'b1;
    r.halt = r.halt | r.trap;
    wen    = wen & ~r.trap; // Trap leaves state untouched
    if (wen) r.rd_waddr = rd;
    if (wen && rd != '0) begin
        r.rd_wdata      = val;
        shadow_regs[rd] = val;
    end
    return r;
endfunction

`endif

// File: sim/tb_hart.sv
/* Testbench for the hart with memories, program builder,
   LFSR stimulus and retire comparison against a reference model */
`timescale 1ns/1ps

module tb_hart import hart_pkg::*;;

    localparam word_t RESET_ADDR = 32'h0000_0100;

    logic       i_clk, i_rst;
    word_t      o_imem_raddr, i_imem_rdata, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    logic       o_dmem_ren, o_dmem_wen;
    byte_mask_t o_dmem_mask;
    retire_t    o_retire;

    word_t imem [256];
    word_t dmem [256];
    word_t prog [$];      // Program under construction
    word_t shadow_pc;
    word_t lfsr_q;
    logic  checking, halt_seen;

    `include "rv_ref_model.svh"

    hart #(.RESET_ADDR(RESET_ADDR)) dut (.*);

    // ============================================================
    // Clock and memories
    // ============================================================
    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    assign i_imem_rdata = imem[o_imem_raddr[9:2]]; // Combinational answer
    assign i_dmem_rdata = dmem[o_dmem_addr[9:2]];

    always @(posedge i_clk) begin
        if (o_dmem_wen) begin
            for (int k = 0; k < 4; k++) begin
                if (o_dmem_mask[k]) dmem[o_dmem_addr[9:2]][8*k +: 8] <= o_dmem_wdata[8*k +: 8];
            end
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else fail_run($sformatf("Error: %s got 0x%h expected 0x%h",
                                                     name, got, exp));
    endtask

    function automatic word_t rand_bits(input int n); // Taps 32, 22, 2, 1
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input int idx); // Unique per address
        word_t a;
        a = word_t'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OP_STORE}; // Base is x0
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // ============================================================
    // Programs
    // ============================================================
    task automatic build_main();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [2:0]  br_f3 [6];
        prog.delete();
        prog.push_back(enc_i(12'h123, 0, 3'd0, 1, OP_IMM));  // x1 = 0x123
        prog.push_back(enc_i(12'hffb, 0, 3'd0, 2, OP_IMM));  // x2 = -5
        prog.push_back({20'h80000, 5'd3, OP_LUI});
        prog.push_back(enc_r(7'h20, 1, 2, 3'd0, 4));         // SUB
        prog.push_back(enc_r(7'h20, 1, 3, 3'd5, 5));         // SRA
        prog.push_back(enc_i(12'h404, 3, 3'd5, 6, OP_IMM));  // SRAI by 4
        prog.push_back(enc_r(7'h00, 1, 2, 3'd2, 7));         // SLT
        prog.push_back(enc_r(7'h00, 1, 2, 3'd3, 8));         // SLTU
        prog.push_back(enc_i(12'h005, 1, 3'd0, 0, OP_IMM));  // x0 must stay zero
        prog.push_back({20'h12345, 5'd9, OP_AUIPC});
        // Stores at every legal offset, then read back
        for (int k = 0; k < 4; k++) prog.push_back(enc_s(12'(64 + k), reg_addr_t'(k + 1), 3'd0));
        for (int k = 0; k < 2; k++) prog.push_back(enc_s(12'(68 + 2*k), reg_addr_t'(k + 4), 3'd1));
        prog.push_back(enc_s(12'h048, 9, 3'd2));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_i(12'(64 + k), 0, 3'd0, 10, OP_LOAD)); // LB
            prog.push_back(enc_i(12'(64 + k), 0, 3'd4, 11, OP_LOAD)); // LBU
        end
        for (int k = 0; k < 2; k++) begin
            prog.push_back(enc_i(12'(68 + 2*k), 0, 3'd1, 12, OP_LOAD)); // LH
            prog.push_back(enc_i(12'(68 + 2*k), 0, 3'd5, 13, OP_LOAD)); // LHU
        end
        prog.push_back(enc_i(12'h048, 0, 3'd2, 14, OP_LOAD));
        // Every branch with less, equal and greater operands
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 0; i < 6; i++) begin
            f3 = br_f3[i];
            prog.push_back(enc_b(13'd8, 2, 1, f3));
            prog.push_back(enc_i(12'h001, 21, 3'd0, 21, OP_IMM));
            prog.push_back(enc_b(13'd8, 1, 1, f3));
            prog.push_back(enc_i(12'h001, 21, 3'd0, 21, OP_IMM));
            prog.push_back(enc_b(13'd8, 1, 2, f3));
            prog.push_back(enc_i(12'h001, 21, 3'd0, 21, OP_IMM));
        end
        prog.push_back(enc_j(21'd8, 22));                    // JAL skips one
        prog.push_back(enc_i(12'h001, 21, 3'd0, 21, OP_IMM));
        prog.push_back({20'h00000, 5'd23, OP_AUIPC});
        prog.push_back(enc_i(12'd13, 23, 3'd0, 24, OP_JALR)); // Odd target with bit 0 cleared
        prog.push_back(enc_i(12'h001, 21, 3'd0, 21, OP_IMM));
        // Random ALU block
        for (int n = 0; n < 40; n++) begin
            f3 = rand_bits(3);
            if (rand_bits(1)) begin
                alt = (f3 == 3'd0 || f3 == 3'd5) ? rand_bits(1) : 1'b0;
                prog.push_back(enc_r({1'b0, alt, 5'b0}, rand_bits(5), rand_bits(5), f3,
                                     rand_bits(5)));
            end else begin
                imm = rand_bits(12);
                if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                prog.push_back(enc_i(imm, rand_bits(5), f3, rand_bits(5), OP_IMM));
            end
        end
        prog.push_back(32'h0010_0073); // EBREAK
    endtask

    task automatic build_trap(input int which);
        prog.delete();
        case (which)
            0: begin // Misaligned half-word load
                prog.push_back(enc_i(12'h041, 0, 3'd0, 1, OP_IMM));
                prog.push_back(enc_i(12'h000, 1, 3'd1, 2, OP_LOAD));
            end
            1: begin // Misaligned word store
                prog.push_back(enc_i(12'h042, 0, 3'd0, 1, OP_IMM));
                prog.push_back({7'd0, 5'd1, 5'd1, 3'd2, 5'd0, OP_STORE});
            end
            2: prog.push_back(32'hffff_ffff);     // Illegal opcode
            default: prog.push_back(enc_j(21'd6, 5)); // Jump target off by two
        endcase
    endtask

    // Reset, load, run to halt, then compare data memory
    task automatic run_program(input int limit);
        int cycles;
        checking  = 1'b0;
        halt_seen = 1'b0;
        @(posedge i_clk);
        #1 i_rst = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i]       = '0;
            dmem[i]       = fill_word(i);
            shadow_mem[i] = fill_word(i);
        end
        foreach (prog[i]) imem[64 + i] = prog[i];
        for (int i = 0; i < 32; i++) shadow_regs[i] = '0;
        shadow_pc = RESET_ADDR;
        repeat (5) @(posedge i_clk);
        #1 i_rst = 1'b0;
        checking = 1'b1;
        cycles   = 0;
        while (!halt_seen) begin
            @(posedge i_clk);
            cycles++;
            if (cycles > limit) fail_run("timeout, the hart never halted");
        end
        for (int i = 0; i < 256; i++) check_word($sformatf("dmem[%0d]", i), dmem[i], shadow_mem[i]);
    endtask

    // ============================================================
    // Retire comparison at mid-cycle where outputs are settled
    // ============================================================
    always @(negedge i_clk) begin
        retire_t exp;
        word_t   inst;
        if (checking) begin
            inst = imem[shadow_pc[9:2]];
            exp  = ref_step(shadow_pc, inst);
            check_word("valid", 32'(o_retire.valid), 32'(exp.valid));
            check_word("trap", 32'(o_retire.trap), 32'(exp.trap));
            check_word("halt", 32'(o_retire.halt), 32'(exp.halt));
            check_word("inst", o_retire.inst, exp.inst);
            check_word("pc", o_retire.pc, exp.pc);
            check_word("next_pc", o_retire.next_pc, exp.next_pc);
            check_word("rd_waddr", 32'(o_retire.rd_waddr), 32'(exp.rd_waddr));
            check_word("rd_wdata", o_retire.rd_wdata, exp.rd_wdata);
            // Data port enables only for an untrapped access
            check_word("dmem_ren", 32'(o_dmem_ren), 32'(inst[6:0] == OP_LOAD && !exp.trap));
            check_word("dmem_wen", 32'(o_dmem_wen), 32'(inst[6:0] == OP_STORE && !exp.trap));
            shadow_pc = exp.next_pc;
            if (exp.halt) begin
                halt_seen = 1'b1;
                checking  = 1'b0;
            end
        end else if (i_rst) begin
            // Nothing retires or writes a register in reset
            check_word("valid", 32'(o_retire.valid), 32'd0);
            check_word("rd_waddr", 32'(o_retire.rd_waddr), 32'd0);
        end
    end

    initial begin
        i_rst     = 1'b1;
        checking  = 1'b0;
        halt_seen = 1'b0;
        lfsr_q    = 32'ha5ab_c452;
        build_main();
        run_program(400);
        for (int t = 0; t < 4; t++) begin
            build_trap(t);
            run_program(20);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
